// File: Bender.yml
package:
  name: pixl_stream

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pixl_pkg.sv
      - hdl/line_rd_if.sv
      - hdl/line_pingpong.sv
      - hdl/half_frame_reader.sv
      - hdl/stream_fifo.sv
      - hdl/pixl_stream_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/pixl_stream_tb.sv

// File: dv/pixl_stream_tb.sv
`timescale 1ns/1ps
`include "pixl_params.svh"

module pixl_stream_tb;
  import pixl_pkg::*;

  localparam int          FRAMES      = 3;
  localparam int          VA          = `PIXL_VA;
  localparam int          FRAME_BEATS = 2 * VA;
  localparam int          TOTAL_BEATS = FRAMES * FRAME_BEATS;
  localparam logic [31:0] SEED        = 32'h49b8;
  // long tready stall early in frame 0
  localparam int          STALL_AT    = 100;
  localparam int          STALL_CYC   = 4000;
  // three frames at half-rate ready plus the stall, wide margin
  localparam int          TIMEOUT_CYC = 80000;

  logic       clk125m;
  logic       rstn;
  logic [3:0] line_wr;
  line_word_t line_data [4];
  wire  [3:0] line_full;
  beat_t      axis_tdata_o;
  logic       axis_tvalid_o;
  logic       axis_tready_i;

  // source pixels per channel, frame and row
  logic [`PIXL_PIX_W-1:0] pix_mem [4][FRAMES][VA];

  int          beats_seen;
  int          cycles;
  int          stall_left;
  bit          stall_done;
  bit          held;
  beat_t       held_beat;
  beat_t       exp_beat;
  logic [31:0] rdy_st;

  pixl_stream_top dut (
    .clk125m       (clk125m),
    .rstn          (rstn),
    .line0_wr_i    (line_wr[0]),
    .line0_data_i  (line_data[0]),
    .line0_full_o  (line_full[0]),
    .line1_wr_i    (line_wr[1]),
    .line1_data_i  (line_data[1]),
    .line1_full_o  (line_full[1]),
    .line2_wr_i    (line_wr[2]),
    .line2_data_i  (line_data[2]),
    .line2_full_o  (line_full[2]),
    .line3_wr_i    (line_wr[3]),
    .line3_data_i  (line_data[3]),
    .line3_full_o  (line_full[3]),
    .axis_tdata_o  (axis_tdata_o),
    .axis_tvalid_o (axis_tvalid_o),
    .axis_tready_i (axis_tready_i)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // lcg step, low bits are weak so callers use bits 16 and up
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [`PIXL_PIX_W-1:0] reverse_pix(input logic [`PIXL_PIX_W-1:0] p);
    logic [`PIXL_PIX_W-1:0] r;
    for (int i = 0; i < `PIXL_PIX_W; i++) begin
      r[i] = p[`PIXL_PIX_W-1-i];
    end
    return r;
  endfunction

  // beat k of frame f
  // upper half bottom-up from ch0/ch1, lower half top-down from ch2/ch3
  function automatic beat_t expected_beat(input int f, input int k);
    beat_t b;
    int    r;
    if (k < VA) begin
      r        = VA - k;
      b.lo.tag = 3'b000;
      b.lo.row = `PIXL_ROW_W'(r);
      b.lo.pix = pix_mem[0][f][r-1];
      b.hi.tag = 3'b010;
      b.hi.row = `PIXL_ROW_W'(r);
      b.hi.pix = reverse_pix(pix_mem[1][f][r-1]);
    end else begin
      r        = k - VA + 1;
      b.lo.tag = 3'b100;
      b.lo.row = `PIXL_ROW_W'(r);
      b.lo.pix = pix_mem[2][f][r-1];
      b.hi.tag = 3'b110;
      b.hi.row = `PIXL_ROW_W'(r);
      b.hi.pix = reverse_pix(pix_mem[3][f][r-1]);
    end
    return b;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input beat_t got, input beat_t exp);
    abort_run($sformatf("MISMATCH t=%0t %s got=%h exp=%h", $time, sig, got, exp));
  endtask

  // one sub-circuit, rows 1..500 per frame, random gaps, stalls on full
  task automatic write_channel(input int ch);
    logic [31:0] st;
    st = SEED + 32'd1 + 32'(ch);
    for (int f = 0; f < FRAMES; f++) begin
      for (int r = 1; r <= VA; r++) begin
        @(negedge clk125m);
        st = lcg_next(st);
        while (line_full[ch] || st[17:16] == 2'b00) begin
          line_wr[ch] = 1'b0;
          @(negedge clk125m);
          st = lcg_next(st);
        end
        line_wr[ch]       = 1'b1;
        line_data[ch].row = `PIXL_ROW_W'(r);
        line_data[ch].pix = pix_mem[ch][f][r-1];
      end
    end
    @(negedge clk125m);
    line_wr[ch] = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // clock and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    clk125m = 1'b0;
    forever #4 clk125m = ~clk125m;
  end

  always @(posedge clk125m) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      abort_run($sformatf("timeout after %0d cycles, %0d beats seen", cycles, beats_seen));
    end
  end

  ////////////////////////////////////////////////////////////
  // tready and output checker
  ////////////////////////////////////////////////////////////

  // half-rate random ready with one long stall
  // outputs only move on the rising edge, so the bus is settled here
  always @(negedge clk125m) begin
    if (rstn) begin
      if (stall_left > 0) begin
        axis_tready_i = 1'b0;
        stall_left--;
        if (stall_left == 0) begin
          assert (line_full == 4'hf)
            else abort_run("line buffers did not report full during the tready stall");
        end
      end else if (!stall_done && beats_seen >= STALL_AT) begin
        stall_done    = 1'b1;
        stall_left    = STALL_CYC;
        axis_tready_i = 1'b0;
      end else begin
        rdy_st        = lcg_next(rdy_st);
        axis_tready_i = rdy_st[16];
      end
      // held beat must not change or vanish
      if (held) begin
        assert (axis_tvalid_o) else abort_run("axis_tvalid_o dropped while tready was low");
        assert (axis_tdata_o == held_beat)
          else report_mismatch("axis_tdata_o", axis_tdata_o, held_beat);
      end
      held      = axis_tvalid_o && !axis_tready_i;
      held_beat = axis_tdata_o;
      // next rising edge takes this beat
      if (axis_tvalid_o && axis_tready_i) begin
        assert (beats_seen < TOTAL_BEATS) else abort_run("more beats than the frames sent");
        exp_beat = expected_beat(beats_seen / FRAME_BEATS, beats_seen % FRAME_BEATS);
        assert (axis_tdata_o == exp_beat)
          else report_mismatch("axis_tdata_o", axis_tdata_o, exp_beat);
        beats_seen++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]  st;
    logic [511:0] wide;
    rstn          = 1'b0;
    line_wr       = 4'h0;
    axis_tready_i = 1'b0;
    beats_seen    = 0;
    cycles        = 0;
    stall_left    = 0;
    stall_done    = 1'b0;
    held          = 1'b0;
    rdy_st        = SEED + 32'd7;
    for (int c = 0; c < 4; c++) begin
      line_data[c] = '0;
    end
    // pixel content for every line of every frame
    st = SEED;
    for (int c = 0; c < 4; c++) begin
      for (int f = 0; f < FRAMES; f++) begin
        for (int r = 0; r < VA; r++) begin
          for (int w = 0; w < 16; w++) begin
            st              = lcg_next(st);
            wide[w*32 +: 32] = st;
          end
          pix_mem[c][f][r] = wide[`PIXL_PIX_W-1:0];
        end
      end
    end
    repeat (16) @(negedge clk125m);
    rstn = 1'b1;
    // idle outputs straight after reset
    assert (!axis_tvalid_o && line_full == 4'h0)
      else abort_run("tvalid or a full flag is high right after reset");
    fork
      write_channel(0);
      write_channel(1);
      write_channel(2);
      write_channel(3);
    join_none
    wait (beats_seen == TOTAL_BEATS);
    // nothing may follow the last frame
    repeat (40) @(negedge clk125m);
    assert (!axis_tvalid_o) else abort_run("extra beat after the last frame");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: hdl/half_frame_reader.sv
`timescale 1ns/1ps
`include "pixl_params.svh"

module half_frame_reader (
  input  logic            clk125m,
  input  logic            rstn,
  line_rd_if.reader       ch0,
  line_rd_if.reader       ch1,
  line_rd_if.reader       ch2,
  line_rd_if.reader       ch3,
  output logic            fifo_wr_o,
  output pixl_pkg::beat_t fifo_din_o,
  input  logic            fifo_near_full_i,
  input  logic            fifo_full_i,
  input  logic            fifo_rd_i
);
  import pixl_pkg::*;

  localparam logic [`PIXL_ROW_W-1:0] LAST = `PIXL_ROW_W'(`PIXL_VA - 1);

  // origin tags per sub-circuit
  localparam logic [`PIXL_TAG_W-1:0] TAG_CH0 = 3'b000;
  localparam logic [`PIXL_TAG_W-1:0] TAG_CH1 = 3'b010;
  localparam logic [`PIXL_TAG_W-1:0] TAG_CH2 = 3'b100;
  localparam logic [`PIXL_TAG_W-1:0] TAG_CH3 = 3'b110;

  typedef enum logic [1:0] {IDLE, UPPER, LOWER} state_t;

  state_t                 state;
  state_t                 nstate;
  logic [`PIXL_ROW_W-1:0] cnt_rd;
  logic                   room;
  logic                   rd_upper;
  logic                   rd_lower;
  logic                   last_rd;
  logic                   upper_lag;
  half_beat_t             h0;
  half_beat_t             h1;
  half_beat_t             h2;
  half_beat_t             h3;

  // horizontal mirror of one line
  function automatic logic [`PIXL_PIX_W-1:0] mirror(input logic [`PIXL_PIX_W-1:0] p);
    logic [`PIXL_PIX_W-1:0] r;
    for (int i = 0; i < `PIXL_PIX_W; i++) begin
      r[i] = p[`PIXL_PIX_W-1-i];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // read issue
  ////////////////////////////////////////////////////////////

  // a beat leaving frees a slot this cycle
  // otherwise leave room for the write already in flight
  assign room = fifo_rd_i || (!fifo_full_i && !(fifo_near_full_i && fifo_wr_o));

  assign rd_upper = (state == UPPER) && !ch0.empty && !ch1.empty && room;
  assign rd_lower = (state == LOWER) && !ch2.empty && !ch3.empty && room;
  assign last_rd  = (rd_upper || rd_lower) && (cnt_rd == LAST);

  // upper half is stored top-down, read it bottom-up
  assign ch0.rd      = rd_upper;
  assign ch1.rd      = rd_upper;
  assign ch0.raddr   = LAST - cnt_rd;
  assign ch1.raddr   = LAST - cnt_rd;
  assign ch0.rd_done = rd_upper && last_rd;
  assign ch1.rd_done = rd_upper && last_rd;

  // lower half in natural order
  assign ch2.rd      = rd_lower;
  assign ch3.rd      = rd_lower;
  assign ch2.raddr   = cnt_rd;
  assign ch3.raddr   = cnt_rd;
  assign ch2.rd_done = rd_lower && last_rd;
  assign ch3.rd_done = rd_lower && last_rd;

  ////////////////////////////////////////////////////////////
  // half sequencing
  ////////////////////////////////////////////////////////////

  always_comb begin
    nstate = state;
    case (state)
      IDLE:    if (!ch0.empty && !ch1.empty) nstate = UPPER;
      UPPER:   if (rd_upper && last_rd) nstate = LOWER;
      LOWER:   if (rd_lower && last_rd) nstate = IDLE;
      default: nstate = IDLE;
    endcase
  end

  always_ff @(posedge clk125m or negedge rstn) begin
    if (!rstn) begin
      state     <= IDLE;
      cnt_rd    <= '0;
      fifo_wr_o <= 1'b0;
      upper_lag <= 1'b0;
    end else begin
      state <= nstate;
      if (rd_upper || rd_lower) begin
        cnt_rd <= last_rd ? '0 : cnt_rd + 1'b1;
      end
      // write lands with the buffer read data
      fifo_wr_o <= rd_upper || rd_lower;
      // mux select lags state to match read latency
      upper_lag <= (state == UPPER);
    end
  end

  ////////////////////////////////////////////////////////////
  // reorder and tag
  ////////////////////////////////////////////////////////////

  // ch1 and ch3 sit mirrored on the sensor
  assign h0 = '{tag: TAG_CH0, row: ch0.rdata.row, pix: ch0.rdata.pix};
  assign h1 = '{tag: TAG_CH1, row: ch1.rdata.row, pix: mirror(ch1.rdata.pix)};
  assign h2 = '{tag: TAG_CH2, row: ch2.rdata.row, pix: ch2.rdata.pix};
  assign h3 = '{tag: TAG_CH3, row: ch3.rdata.row, pix: mirror(ch3.rdata.pix)};

  assign fifo_din_o = upper_lag ? '{hi: h1, lo: h0} : '{hi: h3, lo: h2};

  // room check one cycle earlier must keep the FIFO from overflowing
  a_no_wr_full: assert property (
    @(posedge clk125m) disable iff (!rstn) fifo_wr_o |-> !fifo_full_i
  ) else $error("half_frame_reader: FIFO write while full");

endmodule

// File: hdl/line_pingpong.sv
`timescale 1ns/1ps
`include "pixl_params.svh"

module line_pingpong (
  input  logic                 clk125m,
  input  logic                 rstn,
  input  logic                 wr_i,
  input  pixl_pkg::line_word_t wdata_i,
  output logic                 full_o,
  line_rd_if.buffer            rd
);

  ////////////////////////////////////////////////////////////
  // storage, two banks of one half frame each
  ////////////////////////////////////////////////////////////

  logic [`PIXL_LINE_W-1:0] mem [0:1][0:`PIXL_VA-1];

  logic                   wr_bank;
  logic                   rd_bank;
  // banks holding a complete, unread half frame
  logic [1:0]             fill;
  logic [`PIXL_ROW_W-1:0] waddr;
  logic                   wr_done;

  // rows are 1-based on the wire
  assign waddr   = wdata_i.row - 1'b1;
  // row 500 closes the bank
  assign wr_done = wr_i && (waddr == `PIXL_ROW_W'(`PIXL_VA - 1));

  always_ff @(posedge clk125m) begin
    if (wr_i) begin
      mem[wr_bank][waddr] <= wdata_i;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk125m) begin
    if (rd.rd) begin
      rd.rdata <= mem[rd_bank][rd.raddr];
    end
  end

  ////////////////////////////////////////////////////////////
  // bank pointers and fill level
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk125m or negedge rstn) begin
    if (!rstn) begin
      wr_bank <= 1'b0;
      rd_bank <= 1'b0;
      fill    <= 2'd0;
    end else begin
      // writer moves on once its bank is complete
      if (wr_done) begin
        wr_bank <= ~wr_bank;
      end
      // reader moves on with the last read of a bank
      if (rd.rd_done) begin
        rd_bank <= ~rd_bank;
      end
      case ({wr_done, rd.rd_done})
        2'b10:   fill <= fill + 2'd1;
        2'b01:   fill <= fill - 2'd1;
        default: fill <= fill;
      endcase
    end
  end

  // both levels follow the fill count, so one cycle after the event
  assign rd.empty = (fill == 2'd0);
  assign full_o   = (fill == 2'd2);

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // source must stall while both banks wait for the reader
  a_no_wr_full: assert property (
    @(posedge clk125m) disable iff (!rstn) wr_i |-> !full_o
  ) else $error("line_pingpong: write while full");

  // reader must only address a completed bank
  a_no_rd_empty: assert property (
    @(posedge clk125m) disable iff (!rstn) rd.rd |-> !rd.empty
  ) else $error("line_pingpong: read while empty");

endmodule

// File: hdl/line_rd_if.sv
`timescale 1ns/1ps
`include "pixl_params.svh"

// read side of one ping-pong line buffer
interface line_rd_if;
  import pixl_pkg::*;

  // reader controls
  logic                   rd;
  logic [`PIXL_ROW_W-1:0] raddr;
  // last read of the bank, frees it
  logic                   rd_done;

  // buffer returns, rdata one cycle after rd
  line_word_t             rdata;
  logic                   empty;

  modport reader (output rd, output raddr, output rd_done, input rdata, input empty);

  modport buffer (input rd, input raddr, input rd_done, output rdata, output empty);

endinterface

// File: hdl/pixl_params.svh
`ifndef PIXL_PARAMS_SVH
`define PIXL_PARAMS_SVH

////////////////////////////////////////////////////////////
// line geometry
////////////////////////////////////////////////////////////

// pixels per sensor line
`define PIXL_PIX_W 500
// 1-based row number field
`define PIXL_ROW_W 9
// lines per half frame, also lines per bank
`define PIXL_VA 500
// row field plus pixels
`define PIXL_LINE_W 509

////////////////////////////////////////////////////////////
// output stream
////////////////////////////////////////////////////////////

// origin tag on each 512-bit half
`define PIXL_TAG_W 3
`define PIXL_BEAT_W 1024
`define PIXL_OFIFO_DEPTH 16

`endif

// File: hdl/pixl_pkg.sv
`include "pixl_params.svh"

package pixl_pkg;

  ////////////////////////////////////////////////////////////
  // sensor side
  ////////////////////////////////////////////////////////////

  // one line as delivered by a sub-circuit
  // row sits in bits 508..500
  typedef struct packed {
    logic [`PIXL_ROW_W-1:0] row;
    logic [`PIXL_PIX_W-1:0] pix;
  } line_word_t;

  ////////////////////////////////////////////////////////////
  // stream side
  ////////////////////////////////////////////////////////////

  // tagged line, 512 bits
  typedef struct packed {
    logic [`PIXL_TAG_W-1:0] tag;
    logic [`PIXL_ROW_W-1:0] row;
    logic [`PIXL_PIX_W-1:0] pix;
  } half_beat_t;

  // hi half from sub-circuit 1 or 3
  // lo half from sub-circuit 0 or 2
  typedef struct packed {
    half_beat_t hi;
    half_beat_t lo;
  } beat_t;

endpackage

// File: hdl/pixl_stream_top.sv
`timescale 1ns/1ps

module pixl_stream_top (
  input  logic                 clk125m,
  input  logic                 rstn,
  // sub-circuit line inputs
  input  logic                 line0_wr_i,
  input  pixl_pkg::line_word_t line0_data_i,
  output logic                 line0_full_o,
  input  logic                 line1_wr_i,
  input  pixl_pkg::line_word_t line1_data_i,
  output logic                 line1_full_o,
  input  logic                 line2_wr_i,
  input  pixl_pkg::line_word_t line2_data_i,
  output logic                 line2_full_o,
  input  logic                 line3_wr_i,
  input  pixl_pkg::line_word_t line3_data_i,
  output logic                 line3_full_o,
  // 1024-bit output stream
  output pixl_pkg::beat_t      axis_tdata_o,
  output logic                 axis_tvalid_o,
  input  logic                 axis_tready_i
);
  import pixl_pkg::*;

  beat_t fifo_din;
  logic  fifo_wr;
  logic  fifo_rd;
  logic  fifo_full;
  logic  fifo_near_full;
  logic  fifo_empty;

  // one read port per line buffer
  line_rd_if rd_if [4] ();

  ////////////////////////////////////////////////////////////
  // line buffers
  ////////////////////////////////////////////////////////////

  line_pingpong u_pp0 (
    .clk125m (clk125m),
    .rstn    (rstn),
    .wr_i    (line0_wr_i),
    .wdata_i (line0_data_i),
    .full_o  (line0_full_o),
    .rd      (rd_if[0])
  );

  line_pingpong u_pp1 (
    .clk125m (clk125m),
    .rstn    (rstn),
    .wr_i    (line1_wr_i),
    .wdata_i (line1_data_i),
    .full_o  (line1_full_o),
    .rd      (rd_if[1])
  );

  line_pingpong u_pp2 (
    .clk125m (clk125m),
    .rstn    (rstn),
    .wr_i    (line2_wr_i),
    .wdata_i (line2_data_i),
    .full_o  (line2_full_o),
    .rd      (rd_if[2])
  );

  line_pingpong u_pp3 (
    .clk125m (clk125m),
    .rstn    (rstn),
    .wr_i    (line3_wr_i),
    .wdata_i (line3_data_i),
    .full_o  (line3_full_o),
    .rd      (rd_if[3])
  );

  ////////////////////////////////////////////////////////////
  // reader and output FIFO
  ////////////////////////////////////////////////////////////

  half_frame_reader u_reader (
    .clk125m          (clk125m),
    .rstn             (rstn),
    .ch0              (rd_if[0]),
    .ch1              (rd_if[1]),
    .ch2              (rd_if[2]),
    .ch3              (rd_if[3]),
    .fifo_wr_o        (fifo_wr),
    .fifo_din_o       (fifo_din),
    .fifo_near_full_i (fifo_near_full),
    .fifo_full_i      (fifo_full),
    .fifo_rd_i        (fifo_rd)
  );

  stream_fifo u_ofifo (
    .clk125m     (clk125m),
    .rstn        (rstn),
    .wr_i        (fifo_wr),
    .din_i       (fifo_din),
    .rd_i        (fifo_rd),
    .dout_o      (axis_tdata_o),
    .full_o      (fifo_full),
    .near_full_o (fifo_near_full),
    .empty_o     (fifo_empty)
  );

  // beat leaves on valid and ready
  assign axis_tvalid_o = !fifo_empty;
  assign fifo_rd       = axis_tvalid_o && axis_tready_i;

endmodule

// File: hdl/stream_fifo.sv
`timescale 1ns/1ps
`include "pixl_params.svh"

module stream_fifo #(
  parameter int DEPTH = `PIXL_OFIFO_DEPTH
) (
  input  logic            clk125m,
  input  logic            rstn,
  input  logic            wr_i,
  input  pixl_pkg::beat_t din_i,
  input  logic            rd_i,
  output pixl_pkg::beat_t dout_o,
  output logic            full_o,
  output logic            near_full_o,
  output logic            empty_o
);

  localparam int AW = $clog2(DEPTH);

  logic [`PIXL_BEAT_W-1:0] mem [0:DEPTH-1];
  logic [AW-1:0]           wptr;
  logic [AW-1:0]           rptr;
  logic [AW:0]             count;
  logic                    do_wr;
  logic                    do_rd;

  // overflow and underflow attempts are dropped
  assign do_wr = wr_i && !full_o;
  assign do_rd = rd_i && !empty_o;

  always_ff @(posedge clk125m) begin
    if (do_wr) begin
      mem[wptr] <= din_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk125m or negedge rstn) begin
    if (!rstn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      end
      if (do_rd) begin
        rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head of queue, stable until read
  assign dout_o      = mem[rptr];
  assign empty_o     = (count == '0);
  assign full_o      = (count == (AW+1)'(DEPTH));
  // exactly one free slot
  assign near_full_o = (count == (AW+1)'(DEPTH - 1));

  // sink side only pulls while tvalid is up
  a_no_rd_empty: assert property (
    @(posedge clk125m) disable iff (!rstn) rd_i |-> !empty_o
  ) else $error("stream_fifo: read while empty");

endmodule

// File: pixl_stream.f
+incdir+hdl
hdl/pixl_pkg.sv
hdl/line_rd_if.sv
hdl/line_pingpong.sv
hdl/half_frame_reader.sv
hdl/stream_fifo.sv
hdl/pixl_stream_top.sv
dv/pixl_stream_tb.sv
